// File: filelist.f
rtl/ss_pkg.sv
rtl/ss_controller.sv
rtl/ss_chunk_walker.sv
rtl/ss_mem_port.sv
rtl/ss_state_ram.sv
rtl/ss_stream_top.sv
verification/ss_stream_properties.sv
verification/ss_stream_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the save-state testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -f filelist.f --top-module ss_stream_tb -o ss_stream_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Build failed with status $status"
    exit "$status"
fi

./obj_dir/ss_stream_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: verification/ss_stream_tb.sv
`timescale 1ns/1ns

module ss_stream_tb
    import ss_pkg::*;
();

    localparam logic [SS_ADDR_W-1:0] BASE_ADDR = 32'h0000_1000;
    localparam int RESET_CYCLES = 10;
    localparam int SETTLE_CYCLES = 16;
    localparam int DEPTH0 = 16;
    localparam int DEPTH1 = 8;
    localparam int RAM_WORDS = DEPTH0 + DEPTH1;
    localparam int STREAM_WORDS = RAM_WORDS + 2;
    localparam int CHUNK1_HDR = DEPTH0 + 1;
    localparam int HEAVY_DELAY = 12;
    // Worst case per operation under heavy back-pressure, plus host traffic
    localparam int OP_CYCLES = SETTLE_CYCLES + 8 + STREAM_WORDS * (HEAVY_DELAY + 16);
    localparam int NUM_OPS = 6;
    localparam int NUM_HOST_PASSES = 11;
    localparam int MAX_CYCLES = RESET_CYCLES + NUM_OPS * OP_CYCLES
                                + NUM_HOST_PASSES * RAM_WORDS * 3 + 100;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 do_save;
    logic                 do_restore;
    logic                 host_sel;
    logic [3:0]           host_addr;
    logic                 host_write;
    logic                 host_read;
    logic [63:0]          host_wdata;
    logic [63:0]          host_rdata;
    logic [SS_ADDR_W-1:0] mem_addr;
    logic [63:0]          mem_wdata;
    logic [63:0]          mem_rdata = '0;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_busy = 1'b0;
    logic                 mem_read_complete = 1'b0;
    logic                 busy;
    logic                 done;
    logic                 ss_error;
    ss_state_t            state_out;

    // Memory model state
    logic [63:0] ext_mem [32];
    logic [63:0] rd_data_q [$];
    int          rd_due_q [$];
    int          mem_writes = 0;
    int unsigned busy_pct = 20;
    int unsigned max_delay = 3;
    logic        corrupt_magic = 1'b0;
    int          cycle_cnt = 0;

    // Settle phase tracking
    int          settle_len = 0;
    ss_state_t   settle_from;

    // Expected RAM contents, and the data that overwrites them before a restore
    logic [63:0] shadow [RAM_WORDS];
    logic [63:0] scratch [RAM_WORDS];

    ss_stream_top #(
        .BASE_ADDR(BASE_ADDR),
        .SETTLE_CYCLES(SETTLE_CYCLES),
        .CREDITS(4),
        .DEPTH0(DEPTH0),
        .DEPTH1(DEPTH1)
    ) i_dut (
        .clk, .reset, .do_save, .do_restore,
        .host_sel, .host_addr, .host_write, .host_read, .host_wdata, .host_rdata,
        .mem_addr, .mem_wdata, .mem_rdata, .mem_read, .mem_write, .mem_busy,
        .mem_read_complete, .busy, .done, .ss_error, .ss_state_out(state_out)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("TEST FAILED");
            $fatal(1, "Cycle limit reached");
        end
    end

    ////////////////////////////////////////
    // External memory model

    always @(posedge clk) begin
        logic [31:0] offs;
        logic [63:0] rdata;
        if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle_cnt) begin
            mem_read_complete <= 1'b1;
            mem_rdata <= rd_data_q.pop_front();
            void'(rd_due_q.pop_front());
        end else begin
            mem_read_complete <= 1'b0;
        end
        if ((mem_read || mem_write) && !mem_busy) begin
            offs = (mem_addr - BASE_ADDR) >> 3;
            if (mem_write) begin
                ext_mem[offs[4:0]] <= mem_wdata;
                mem_writes <= mem_writes + 1;
            end else begin
                rdata = ext_mem[offs[4:0]];
                if (corrupt_magic && offs == CHUNK1_HDR) begin
                    rdata[63:48] = ~rdata[63:48];
                end
                rd_data_q.push_back(rdata);
                rd_due_q.push_back(cycle_cnt + int'($urandom_range(max_delay, 1)));
            end
        end
        mem_busy <= ($urandom_range(99, 0) < busy_pct);
    end

    ////////////////////////////////////////
    // Reference and checks

    function automatic int depth_of(input int c);
        return (c == 0) ? DEPTH0 : DEPTH1;
    endfunction

    // Header, chunk 0 data, header, chunk 1 data
    function automatic logic [63:0] ref_stream_word(input int idx);
        if (idx == 0) begin
            return {SS_MAGIC, 8'd0, 8'd0, 32'(DEPTH0)};
        end else if (idx <= DEPTH0) begin
            return shadow[idx - 1];
        end else if (idx == CHUNK1_HDR) begin
            return {SS_MAGIC, 8'd1, 8'd0, 32'(DEPTH1)};
        end
        return shadow[idx - 2];
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Settle lasts a fixed time and leads into the matching walk phase
    always @(posedge clk) begin
        if (reset) begin
            settle_len <= 0;
        end else if (state_out == SAVE_SETTLE || state_out == RESTORE_SETTLE) begin
            settle_len <= settle_len + 1;
            settle_from <= state_out;
        end else if (settle_len != 0) begin
            check_value(64'(settle_len), 64'(SETTLE_CYCLES), "settle cycles");
            check_value(64'(state_out),
                        (settle_from == SAVE_SETTLE) ? 64'(SAVING) : 64'(RESTORING),
                        "state after settle");
            settle_len <= 0;
        end
    end

    task automatic host_write_word(input logic sel, input logic [3:0] addr,
                                   input logic [63:0] data);
        @(posedge clk);
        host_sel <= sel;
        host_addr <= addr;
        host_wdata <= data;
        host_write <= 1'b1;
        @(posedge clk);
        host_write <= 1'b0;
    endtask

    task automatic host_read_check(input logic sel, input logic [3:0] addr,
                                   input logic [63:0] expected);
        @(posedge clk);
        host_sel <= sel;
        host_addr <= addr;
        host_read <= 1'b1;
        @(posedge clk);
        host_read <= 1'b0;
        @(posedge clk);
        check_value(host_rdata, expected, $sformatf("RAM %0d word %0d readback", sel, addr));
    endtask

    task automatic fill_rams(input bit to_shadow);
        logic [63:0] data;
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < depth_of(c); a++) begin
                data = {$urandom, $urandom};
                host_write_word(1'(c), 4'(a), data);
                if (to_shadow) begin
                    shadow[c * DEPTH0 + a] = data;
                end else begin
                    scratch[c * DEPTH0 + a] = data;
                end
            end
        end
    endtask

    task automatic check_rams();
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < depth_of(c); a++) begin
                host_read_check(1'(c), 4'(a), shadow[c * DEPTH0 + a]);
            end
        end
    endtask

    task automatic start_op(input bit restore);
        @(posedge clk);
        do_save <= ~restore;
        do_restore <= restore;
        @(posedge clk);
        do_save <= 1'b0;
        do_restore <= 1'b0;
        @(posedge clk);
        check_value(64'(state_out), restore ? 64'(RESTORE_SETTLE) : 64'(SAVE_SETTLE),
                    "state after request");
        check_value(64'(busy), 64'd1, "busy after request");
    endtask

    // FINISH lasts one cycle, then the controller is idle again
    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
        end
        @(posedge clk);
        check_value(64'(state_out), 64'(IDLE), "state after done");
        check_value(64'(busy), 64'd0, "busy after done");
    endtask

    // Host writes issued during the save must not land
    task automatic run_save(input int blocked_writes);
        logic sel;
        int   writes_before;
        writes_before = mem_writes;
        start_op(1'b0);
        for (int i = 0; i < blocked_writes; i++) begin
            sel = 1'($urandom_range(1, 0));
            host_write_word(sel, 4'($urandom_range(depth_of(sel) - 1, 0)), {$urandom, $urandom});
            check_value(64'(busy), 64'd1, "busy during blocked host write");
        end
        wait_done();
        check_value(64'(mem_writes - writes_before), 64'(STREAM_WORDS), "stream word count");
        for (int i = 0; i < STREAM_WORDS; i++) begin
            check_value(ext_mem[i], ref_stream_word(i), $sformatf("stream word %0d", i));
        end
    endtask

    task automatic run_restore(input bit expect_error);
        start_op(1'b1);
        wait_done();
        check_value(64'(ss_error), 64'(expect_error), "ss_error at done");
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial begin
        reset = 1'b1;
        do_save = 1'b0;
        do_restore = 1'b0;
        host_sel = 1'b0;
        host_addr = '0;
        host_write = 1'b0;
        host_read = 1'b0;
        host_wdata = '0;
        void'($urandom(32'h6d3a));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        fill_rams(1'b1);
        check_rams();
        run_save(0);
        fill_rams(1'b0);
        run_restore(1'b0);
        check_rams();

        // Heavy back-pressure
        busy_pct = 75;
        max_delay = HEAVY_DELAY;
        fill_rams(1'b1);
        run_save(0);
        fill_rams(1'b0);
        run_restore(1'b0);
        check_rams();

        busy_pct = 20;
        max_delay = 3;
        fill_rams(1'b1);
        run_save(4);
        check_rams();

        // Bad chunk 1 header, chunk 1 keeps the overwritten data
        corrupt_magic = 1'b1;
        fill_rams(1'b0);
        run_restore(1'b1);
        for (int a = 0; a < DEPTH1; a++) begin
            shadow[DEPTH0 + a] = scratch[DEPTH0 + a];
        end
        check_rams();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: verification/ss_stream_properties.sv
`timescale 1ns/1ns

module ss_stream_properties
    import ss_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input logic                 mem_read,
    input logic                 mem_write,
    input logic                 mem_busy,
    input logic [SS_ADDR_W-1:0] mem_addr,
    input logic [63:0]          mem_wdata,
    input logic                 busy,
    input logic                 done
);

    a_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    // Request stays put until the memory takes it
    a_request_held: assert property (@(posedge clk) disable iff (reset)
        (mem_read || mem_write) && mem_busy |=>
            $stable(mem_read) && $stable(mem_write) && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request changed while mem_busy high");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done high for more than one cycle");

    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> !busy)
        else $error("busy high after reset");

endmodule

bind ss_stream_top ss_stream_properties i_props (
    .clk, .reset, .mem_read, .mem_write, .mem_busy, .mem_addr, .mem_wdata, .busy, .done
);

// File: rtl/ss_stream_top.sv
`timescale 1ns/1ns

module ss_stream_top
    import ss_pkg::*;
#(
    parameter logic [SS_ADDR_W-1:0] BASE_ADDR = 32'h0000_1000,
    parameter int                   SETTLE_CYCLES = 16,
    parameter int                   CREDITS = 4,
    parameter int                   DEPTH0 = 16,
    parameter int                   DEPTH1 = 8,
    parameter logic [7:0]           INDEX0 = 8'd0,
    parameter logic [7:0]           INDEX1 = 8'd1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 do_save,
    input  logic                 do_restore,

    input  logic                 host_sel,
    input  logic [$clog2((DEPTH0 > DEPTH1) ? DEPTH0 : DEPTH1)-1:0] host_addr,
    input  logic                 host_write,
    input  logic                 host_read,
    input  logic [63:0]          host_wdata,
    output logic [63:0]          host_rdata,

    output logic [SS_ADDR_W-1:0] mem_addr,
    output logic [63:0]          mem_wdata,
    input  logic [63:0]          mem_rdata,
    output logic                 mem_read,
    output logic                 mem_write,
    input  logic                 mem_busy,
    input  logic                 mem_read_complete,

    output logic                 busy,
    output logic                 done,
    output logic                 ss_error,
    output ss_state_t            ss_state_out
);

    logic        start_save;
    logic        start_restore;
    logic        walk_done;
    logic        walk_error;
    ss_dev_req_t dev_req;
    ss_dev_rsp_t dev_rsp;
    ss_dev_rsp_t dev_rsp0;
    ss_dev_rsp_t dev_rsp1;
    logic        wr_valid;
    ss_word_u    wr_word;
    logic        wr_credit;
    logic        rd_start;
    logic [31:0] rd_count;
    logic        rd_credit;
    ss_word_u    rd_word;
    logic        rd_valid;
    logic [63:0] host_rdata0;
    logic [63:0] host_rdata1;
    logic        host_sel_q;

    assign dev_rsp = dev_rsp0 | dev_rsp1;
    assign host_rdata = host_sel_q ? host_rdata1 : host_rdata0;

    // Selects which RAM answers the pending read
    always_ff @(posedge clk) begin
        if (host_read) begin
            host_sel_q <= host_sel;
        end
    end

    ////////////////////////////////////////
    // Save-state engine

    ss_controller #(.SETTLE_CYCLES(SETTLE_CYCLES)) i_controller (
        .clk, .reset, .do_save, .do_restore, .walk_done, .walk_error,
        .start_save, .start_restore, .busy, .done, .ss_error,
        .state(ss_state_out)
    );

    ss_chunk_walker #(.CREDITS(CREDITS)) i_walker (
        .clk, .reset, .start_save, .start_restore, .dev_rsp, .wr_credit,
        .rd_word, .rd_valid, .walk_done, .walk_error, .dev_req, .wr_valid,
        .wr_word, .rd_start, .rd_count, .rd_credit
    );

    ss_mem_port #(.BASE_ADDR(BASE_ADDR), .CREDITS(CREDITS)) i_mem_port (
        .clk, .reset, .wr_valid, .wr_word, .rd_start, .rd_count, .rd_credit,
        .mem_rdata, .mem_busy, .mem_read_complete, .wr_credit, .rd_word,
        .rd_valid, .mem_addr, .mem_wdata, .mem_read, .mem_write
    );

    ////////////////////////////////////////
    // State RAMs

    ss_state_ram #(.DEPTH(DEPTH0), .INDEX(INDEX0)) i_ram0 (
        .clk, .reset, .blocked(busy),
        .host_addr(host_addr[$clog2(DEPTH0)-1:0]),
        .host_write(host_write & ~host_sel),
        .host_read(host_read & ~host_sel),
        .host_wdata, .dev_req, .host_rdata(host_rdata0), .dev_rsp(dev_rsp0)
    );

    ss_state_ram #(.DEPTH(DEPTH1), .INDEX(INDEX1)) i_ram1 (
        .clk, .reset, .blocked(busy),
        .host_addr(host_addr[$clog2(DEPTH1)-1:0]),
        .host_write(host_write & host_sel),
        .host_read(host_read & host_sel),
        .host_wdata, .dev_req, .host_rdata(host_rdata1), .dev_rsp(dev_rsp1)
    );

endmodule

// File: rtl/ss_state_ram.sv
`timescale 1ns/1ns

module ss_state_ram
    import ss_pkg::*;
#(
    parameter int         DEPTH = 16,
    parameter logic [7:0] INDEX = 8'd0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     blocked,
    input  logic [$clog2(DEPTH)-1:0] host_addr,
    input  logic                     host_write,
    input  logic                     host_read,
    input  logic [63:0]              host_wdata,
    input  ss_dev_req_t              dev_req,
    output logic [63:0]              host_rdata,
    output ss_dev_rsp_t              dev_rsp
);

    localparam int AW = $clog2(DEPTH);

    logic [63:0] mem [DEPTH];
    logic [63:0] dev_rdata;
    logic        sel;
    logic        rd_ack;

    assign sel = (dev_req.index == INDEX);

    // Zero when not selected so responses can be ORed
    assign dev_rsp.ack = rd_ack | (sel & dev_req.write);
    assign dev_rsp.size = (sel & dev_req.query) ? 16'(DEPTH) : 16'd0;
    assign dev_rsp.rdata = rd_ack ? dev_rdata : 64'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= sel & dev_req.read;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && dev_req.write) begin
            mem[dev_req.addr[AW-1:0]] <= dev_req.wdata;
        end else if (host_write && !blocked) begin
            mem[host_addr] <= host_wdata;
        end
        if (host_read && !blocked) begin
            host_rdata <= mem[host_addr];
        end
        dev_rdata <= mem[dev_req.addr[AW-1:0]];
    end

endmodule

// File: rtl/ss_mem_port.sv
`timescale 1ns/1ns

module ss_mem_port
    import ss_pkg::*;
#(
    parameter logic [SS_ADDR_W-1:0] BASE_ADDR = '0,
    parameter int                   CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_valid,
    input  ss_word_u             wr_word,
    input  logic                 rd_start,
    input  logic [31:0]          rd_count,
    input  logic                 rd_credit,
    input  logic [63:0]          mem_rdata,
    input  logic                 mem_busy,
    input  logic                 mem_read_complete,
    output logic                 wr_credit,
    output ss_word_u             rd_word,
    output logic                 rd_valid,
    output logic [SS_ADDR_W-1:0] mem_addr,
    output logic [63:0]          mem_wdata,
    output logic                 mem_read,
    output logic                 mem_write
);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CW = $clog2(CREDITS + 1);

    ss_word_u             fifo [CREDITS];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CW-1:0]        fifo_cnt;
    logic [CW-1:0]        rd_cred;
    logic [31:0]          rd_left;
    logic [SS_ADDR_W-1:0] next_addr;
    logic                 active;
    logic                 load;
    logic                 load_write;
    logic                 load_read;
    logic                 new_op;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Request register is free when empty or taken this cycle
    assign load = ~(mem_read | mem_write) | ~mem_busy;
    // Writes drain first
    assign load_write = load & (fifo_cnt != '0);
    assign load_read = load & (fifo_cnt == '0) & (rd_left != 32'd0) & (rd_cred != '0);
    assign new_op = ~active & (wr_valid | (rd_start & (rd_count != 32'd0)));
    assign wr_credit = mem_write & ~mem_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
            rd_cred <= CW'(CREDITS);
            rd_left <= 32'd0;
            active <= 1'b0;
            next_addr <= BASE_ADDR;
            mem_read <= 1'b0;
            mem_write <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mem_read_complete;
            fifo_cnt <= fifo_cnt + CW'(wr_valid) - CW'(load_write);
            rd_cred <= rd_cred + CW'(rd_credit) - CW'(load_read);

            if (wr_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (load_write) begin
                rd_ptr <= ptr_next(rd_ptr);
            end

            if (rd_start) begin
                rd_left <= rd_count;
            end else if (load_read) begin
                rd_left <= rd_left - 32'd1;
            end

            if (rd_start && rd_count == 32'd0) begin
                active <= 1'b0;
            end else if (new_op) begin
                active <= 1'b1;
            end

            if (load) begin
                mem_write <= load_write;
                mem_read <= load_read;
            end

            if (new_op) begin
                next_addr <= BASE_ADDR;
            end else if (load_write || load_read) begin
                next_addr <= next_addr + SS_ADDR_W'(8);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            fifo[wr_ptr] <= wr_word;
        end
        if (load_write || load_read) begin
            mem_addr <= next_addr;
        end
        if (load_write) begin
            mem_wdata <= fifo[rd_ptr].data;
        end
        if (mem_read_complete) begin
            rd_word.data <= mem_rdata;
        end
    end

endmodule

// File: rtl/ss_chunk_walker.sv
`timescale 1ns/1ns

module ss_chunk_walker
    import ss_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_save,
    input  logic        start_restore,
    input  ss_dev_rsp_t dev_rsp,
    input  logic        wr_credit,
    input  ss_word_u    rd_word,
    input  logic        rd_valid,
    output logic        walk_done,
    output logic        walk_error,
    output ss_dev_req_t dev_req,
    output logic        wr_valid,
    output ss_word_u    wr_word,
    output logic        rd_start,
    output logic [31:0] rd_count,
    output logic        rd_credit
);

    localparam int CW = $clog2(CREDITS + 1);

    localparam logic [3:0] W_IDLE      = 4'd0;
    localparam logic [3:0] W_QUERY     = 4'd1;
    localparam logic [3:0] W_SAVE_HDR  = 4'd2;
    localparam logic [3:0] W_SAVE_RD   = 4'd3;
    localparam logic [3:0] W_SAVE_WAIT = 4'd4;
    localparam logic [3:0] W_FLUSH     = 4'd5;
    localparam logic [3:0] W_REST_HDR  = 4'd6;
    localparam logic [3:0] W_REST_DATA = 4'd7;
    localparam logic [3:0] W_DRAIN     = 4'd8;
    localparam logic [3:0] W_END       = 4'd9;

    logic [3:0]    phase;
    logic          restoring;
    logic [15:0]   size;
    logic [CW-1:0] credit;
    logic          send;

    // Read credit was taken when the device read went out
    assign send = ((phase == W_SAVE_HDR) && (credit != '0)) ||
                  ((phase == W_SAVE_WAIT) && dev_rsp.ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= W_IDLE;
            restoring <= 1'b0;
            credit <= CW'(CREDITS);
            walk_done <= 1'b0;
            walk_error <= 1'b0;
            wr_valid <= 1'b0;
            rd_start <= 1'b0;
            rd_credit <= 1'b0;
            dev_req.query <= 1'b0;
            dev_req.read <= 1'b0;
            dev_req.write <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            wr_valid <= 1'b0;
            rd_start <= 1'b0;
            rd_credit <= rd_valid;
            dev_req.query <= 1'b0;
            dev_req.read <= 1'b0;
            dev_req.write <= 1'b0;
            credit <= credit + CW'(wr_credit) - CW'(send);

            case (phase)
                W_IDLE: begin
                    if (start_save || start_restore) begin
                        restoring <= start_restore;
                        walk_error <= 1'b0;
                        dev_req.index <= 8'd0;
                        dev_req.query <= 1'b1;
                        phase <= W_QUERY;
                    end
                end

                // Size comes back in the query cycle, zero past the last chunk
                W_QUERY: begin
                    size <= dev_rsp.size;
                    dev_req.addr <= 16'd0;
                    if (dev_rsp.size == 16'd0) begin
                        phase <= restoring ? W_END : W_FLUSH;
                    end else if (restoring) begin
                        rd_start <= 1'b1;
                        rd_count <= 32'(dev_rsp.size) + 32'd1;
                        phase <= W_REST_HDR;
                    end else begin
                        phase <= W_SAVE_HDR;
                    end
                end

                ////////////////////////////////////////
                // Save
                W_SAVE_HDR: begin
                    if (credit != '0) begin
                        wr_valid <= 1'b1;
                        wr_word.header <= '{magic: SS_MAGIC, index: dev_req.index,
                                            reserved: 8'd0, count: 32'(size)};
                        phase <= W_SAVE_RD;
                    end
                end

                W_SAVE_RD: begin
                    if (dev_req.addr == size) begin
                        dev_req.index <= dev_req.index + 1'b1;
                        dev_req.query <= 1'b1;
                        phase <= W_QUERY;
                    end else if (credit != '0) begin
                        dev_req.read <= 1'b1;
                        phase <= W_SAVE_WAIT;
                    end
                end

                W_SAVE_WAIT: begin
                    if (dev_rsp.ack) begin
                        wr_valid <= 1'b1;
                        wr_word.data <= dev_rsp.rdata;
                        dev_req.addr <= dev_req.addr + 1'b1;
                        phase <= W_SAVE_RD;
                    end
                end

                // All credits back means every word reached memory
                W_FLUSH: begin
                    if (credit == CW'(CREDITS)) begin
                        phase <= W_END;
                    end
                end

                ////////////////////////////////////////
                // Restore
                W_REST_HDR: begin
                    if (rd_valid) begin
                        if (rd_word.header.magic != SS_MAGIC ||
                            rd_word.header.index != dev_req.index) begin
                            walk_error <= 1'b1;
                            phase <= W_DRAIN;
                        end else begin
                            phase <= W_REST_DATA;
                        end
                    end
                end

                W_REST_DATA: begin
                    if (dev_req.write) begin
                        dev_req.addr <= dev_req.addr + 1'b1;
                    end
                    if (rd_valid) begin
                        dev_req.write <= 1'b1;
                        dev_req.wdata <= rd_word.data;
                    end else if (dev_req.addr == size) begin
                        dev_req.index <= dev_req.index + 1'b1;
                        dev_req.query <= 1'b1;
                        phase <= W_QUERY;
                    end
                end

                // Bad header, swallow the rest of the chunk
                W_DRAIN: begin
                    if (dev_req.addr == size) begin
                        phase <= W_END;
                    end else if (rd_valid) begin
                        dev_req.addr <= dev_req.addr + 1'b1;
                    end
                end

                // Zero-length rd_start closes the stream operation
                W_END: begin
                    walk_done <= 1'b1;
                    rd_start <= 1'b1;
                    rd_count <= 32'd0;
                    phase <= W_IDLE;
                end

                default: begin
                    phase <= W_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/ss_controller.sv
`timescale 1ns/1ns

module ss_controller
    import ss_pkg::*;
#(
    parameter int SETTLE_CYCLES = 16
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      do_save,
    input  logic      do_restore,
    input  logic      walk_done,
    input  logic      walk_error,
    output logic      start_save,
    output logic      start_restore,
    output logic      busy,
    output logic      done,
    output logic      ss_error,
    output ss_state_t state
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] settle_cnt;
    logic             settle_end;

    assign settle_end = (settle_cnt == CNT_W'(SETTLE_CYCLES - 1));
    assign busy = (state != IDLE);
    assign done = (state == FINISH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            settle_cnt <= '0;
            start_save <= 1'b0;
            start_restore <= 1'b0;
            ss_error <= 1'b0;
        end else begin
            start_save <= 1'b0;
            start_restore <= 1'b0;
            settle_cnt <= settle_cnt + 1'b1;

            case (state)
                IDLE: begin
                    // Settle count starts on the first settle cycle
                    settle_cnt <= '0;
                    if (do_save) begin
                        state <= SAVE_SETTLE;
                        ss_error <= 1'b0;
                    end else if (do_restore) begin
                        state <= RESTORE_SETTLE;
                        ss_error <= 1'b0;
                    end
                end

                SAVE_SETTLE: begin
                    if (settle_end) begin
                        start_save <= 1'b1;
                        state <= SAVING;
                    end
                end

                SAVING: begin
                    if (walk_done) begin
                        state <= FINISH;
                    end
                end

                RESTORE_SETTLE: begin
                    if (settle_end) begin
                        start_restore <= 1'b1;
                        state <= RESTORING;
                    end
                end

                RESTORING: begin
                    if (walk_done) begin
                        ss_error <= walk_error;
                        state <= FINISH;
                    end
                end

                FINISH: begin
                    state <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/ss_pkg.sv
package ss_pkg;

    // External memory address width
    localparam int SS_ADDR_W = 32;

    // Marks a valid chunk header
    localparam logic [15:0] SS_MAGIC = 16'h5353;

    typedef struct packed {
        logic [15:0] magic;
        logic [7:0]  index;
        logic [7:0]  reserved;
        logic [31:0] count;
    } ss_header_t;

    // One stream word, either a chunk header or payload
    typedef union packed {
        logic [63:0] data;
        ss_header_t  header;
    } ss_word_u;

    typedef struct packed {
        logic [7:0]  index;
        logic [15:0] addr;
        logic        query;
        logic        read;
        logic        write;
        logic [63:0] wdata;
    } ss_dev_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] size;
        logic [63:0] rdata;
    } ss_dev_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        SAVE_SETTLE,
        SAVING,
        RESTORE_SETTLE,
        RESTORING,
        FINISH
    } ss_state_t;

endpackage
